// ==== verilog/rf_cfg_pkg.sv ====
// Geometry of the register file banks
// Shared by the write controller, the latch array and the write interface
package rf_cfg_pkg;

  // --------------------
  // Address geometry
  // --------------------

  // Full register address: one bank bit above the index
  localparam int RF_ADDR_W = 6;

  // Index of a word inside one bank
  localparam int RF_IDX_W = 5;

  // --------------------
  // Word counts
  // --------------------

  // Words per bank, integer and floating point alike
  localparam int RF_BANK_WORDS = 2 ** RF_IDX_W;

  // Word clocks and select bits when both banks exist
  // Word 0 of this range is integer x0 and never gets a clock
  localparam int RF_MAX_WORDS = 2 * RF_BANK_WORDS;

  // Number of read ports on the array
  localparam int RF_RD_PORTS = 3;

endpackage : rf_cfg_pkg

// ==== verilog/rf_addr_pkg.sv ====
// Register address encoding
// One 6-bit word, seen flat by the decoders and as bank plus index
// by the read multiplexers and the bank masking
package rf_addr_pkg;

  import rf_cfg_pkg::*;

  // --------------------
  // Bank select
  // --------------------

  // Top address bit names the bank
  typedef enum logic [0:0] {
    bank_int = 1'b0,
    bank_fp  = 1'b1
  } rf_bank_e;

  // --------------------
  // Address views
  // --------------------

  // Bank view: bank bit on top, index below
  typedef struct packed {
    rf_bank_e              bank;
    logic [RF_IDX_W-1:0]   idx;
  } rf_bank_addr_t;

  // Same address word, two decodes
  // flat: word number 0..63 for the one-hot decoders
  // bank: bank and index for read muxing and masking
  typedef union packed {
    logic [RF_ADDR_W-1:0]  flat;
    rf_bank_addr_t         bank;
  } rf_addr_u;

endpackage : rf_addr_pkg

// ==== verilog/rf_clock_gate.sv ====
`timescale 1ns/1ns

// Integrated clock gating cell
// Enable is captured by a latch that is open while the clock is low,
// so the gated clock never glitches inside a high phase
module rf_clock_gate (
  input  logic clk_i,
  input  logic en_i,
  input  logic test_en_i,
  output logic clk_o
);

  // Latched enable, stable through the high phase
  logic en_q;

  // Transparent while clk_i is low
  // Test enable forces the gate open, as in scan mode
  always_latch
  begin
    if (!clk_i)
      en_q <= en_i | test_en_i;
  end

  // Gated clock
  assign clk_o = clk_i & en_q;

endmodule : rf_clock_gate

// ==== verilog/rf_wr_if.sv ====
`timescale 1ns/1ns

// Write bundle from the write controller to the latch array
// Everything here is already sampled on the global write clock,
// except the word clocks which are the gated clocks themselves
interface rf_wr_if #(
  parameter int data_width = 32
);

  import rf_cfg_pkg::*;

  // One gated clock per word, bit 0 is integer x0 and stays low
  logic [RF_MAX_WORDS-1:0]  word_clk;

  // Registered one-hot word selects of both ports
  // Port A's select qualifies a write, port B's also picks the data
  logic [RF_MAX_WORDS-1:0]  sel_a_q;
  logic [RF_MAX_WORDS-1:0]  sel_b_q;

  // Sampled write data
  logic [data_width-1:0]    wdata_a_q;
  logic [data_width-1:0]    wdata_b_q;

  // Controller side drives the bundle
  modport ctrl (
    output word_clk,
    output sel_a_q,
    output sel_b_q,
    output wdata_a_q,
    output wdata_b_q
  );

  // Array side only consumes it
  modport array (
    input  word_clk,
    input  sel_a_q,
    input  sel_b_q,
    input  wdata_a_q,
    input  wdata_b_q
  );

endinterface : rf_wr_if

// ==== verilog/rf_write_ctrl.sv ====
`timescale 1ns/1ns

// Write controller of the latch register file
// Global clock gate, write sample registers, bank masking,
// one-hot word decoders and the per-word clock gates
module rf_write_ctrl #(
  parameter int data_width = 32,
  parameter int fpu_en     = 1
) (
  input  logic                   clk_int,
  input  logic                   rst_n,
  input  logic                   test_en_i,
  input  logic                   fregfile_disable_i,

  // Write port A
  input  rf_addr_pkg::rf_addr_u  waddr_a_i,
  input  logic [data_width-1:0]  wdata_a_i,
  input  logic                   we_a_i,

  // Write port B
  input  rf_addr_pkg::rf_addr_u  waddr_b_i,
  input  logic [data_width-1:0]  wdata_b_i,
  input  logic                   we_b_i,

  // Sampled write bundle towards the array
  rf_wr_if.ctrl                  wr
);

  import rf_cfg_pkg::*;
  import rf_addr_pkg::*;

  // Words that exist, integer bank only without an FPU
  localparam int num_words = (fpu_en != 0) ? RF_MAX_WORDS : RF_BANK_WORDS;

  // FP bank present and not disabled at run time
  logic                     fp_ena;

  // Write addresses after bank masking
  rf_addr_u                 waddr_a;
  rf_addr_u                 waddr_b;

  // Combinational one-hot selects, already qualified by we
  logic [RF_MAX_WORDS-1:0]  sel_a;
  logic [RF_MAX_WORDS-1:0]  sel_b;

  // Global write clock, runs only on write cycles or in test mode
  logic                     clk_wr;

  // --------------------
  // Helpers
  // --------------------

  // Fold FP addresses onto the integer bank
  function automatic rf_addr_u mask_bank(input rf_addr_u addr, input logic ena);
    rf_addr_u res;
    res = addr;
    if (!ena)
      res.bank.bank = bank_int;
    return res;
  endfunction

  // Flat address to one-hot word select
  // Word 0 is never selected, words past the last bank stay zero
  function automatic logic [RF_MAX_WORDS-1:0] decode_word(
    input rf_addr_u addr,
    input logic     we
  );
    logic [RF_MAX_WORDS-1:0] sel;
    sel = '0;
    for (int w = 1; w < num_words; w++)
    begin
      if (we && (int'(addr.flat) == w))
        sel[w] = 1'b1;
    end
    return sel;
  endfunction

  // --------------------
  // Address masking
  // --------------------

  // Absent FP bank behaves like a disabled one
  assign fp_ena = (fpu_en != 0) & ~fregfile_disable_i;

  assign waddr_a = mask_bank(waddr_a_i, fp_ena);
  assign waddr_b = mask_bank(waddr_b_i, fp_ena);

  // --------------------
  // Write decoders
  // --------------------

  assign sel_a = decode_word(waddr_a, we_a_i);
  assign sel_b = decode_word(waddr_b, we_b_i);

  // --------------------
  // Sample registers
  // --------------------

  // Global gate opens on any write strobe
  rf_clock_gate u_cg_global (
    .clk_i     (clk_int),
    .en_i      (we_a_i | we_b_i),
    .test_en_i (test_en_i),
    .clk_o     (clk_wr)
  );

  // Data only moves for an enabled port
  // Selects follow every global edge, so they drop back to zero
  // when the gate ticks without a write (test mode)
  always_ff @(posedge clk_wr or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr.wdata_a_q <= '0;
      wr.wdata_b_q <= '0;
      wr.sel_a_q   <= '0;
      wr.sel_b_q   <= '0;
    end
    else
    begin
      if (we_a_i)
        wr.wdata_a_q <= wdata_a_i;
      if (we_b_i)
        wr.wdata_b_q <= wdata_b_i;
      wr.sel_a_q <= sel_a;
      wr.sel_b_q <= sel_b;
    end
  end

  // --------------------
  // Word clock gates
  // --------------------

  // Enable is captured before the global edge, so the word clock
  // is high in the phase right after the sample edge
  for (genvar w = 0; w < RF_MAX_WORDS; w++)
  begin : g_word
    if ((w > 0) && (w < num_words))
    begin : g_cg
      rf_clock_gate u_cg_word (
        .clk_i     (clk_wr),
        .en_i      (sel_a[w] | sel_b[w]),
        .test_en_i (test_en_i),
        .clk_o     (wr.word_clk[w])
      );
    end
    else
    begin : g_off
      // x0 and missing FP words have no storage to clock
      assign wr.word_clk[w] = 1'b0;
    end
  end

endmodule : rf_write_ctrl

// ==== verilog/rf_latch_array.sv ====
`timescale 1ns/1ns

// Latch storage of both banks plus the three read multiplexers
// Latches have no reset, contents are unknown until written
module rf_latch_array #(
  parameter int data_width = 32,
  parameter int fpu_en     = 1
) (
  input  logic                   fregfile_disable_i,

  // Read addresses
  input  rf_addr_pkg::rf_addr_u  raddr_a_i,
  input  rf_addr_pkg::rf_addr_u  raddr_b_i,
  input  rf_addr_pkg::rf_addr_u  raddr_c_i,

  // Sampled write bundle
  rf_wr_if.array                 wr,

  // Read data, combinational
  output logic [data_width-1:0]  rdata_a_o,
  output logic [data_width-1:0]  rdata_b_o,
  output logic [data_width-1:0]  rdata_c_o
);

  import rf_cfg_pkg::*;
  import rf_addr_pkg::*;

  // Integer words 1..31, x0 has no storage
  logic [data_width-1:0]  mem_int [1:RF_BANK_WORDS-1];

  // FP bank reads reach FP storage only when enabled
  logic                   fp_ena;

  // Read ports gathered for one shared mux description
  rf_addr_u               raddr    [RF_RD_PORTS];
  logic [data_width-1:0]  rdata    [RF_RD_PORTS];
  logic [data_width-1:0]  rdata_fp [RF_RD_PORTS];

  // --------------------
  // Integer bank
  // --------------------

  // Word opens while its clock is high
  // Port B wins on a shared word through its select
  always_latch
  begin
    for (int k = 1; k < RF_BANK_WORDS; k++)
    begin
      if (wr.word_clk[k] && (wr.sel_a_q[k] || wr.sel_b_q[k]))
        mem_int[k] <= wr.sel_b_q[k] ? wr.wdata_b_q : wr.wdata_a_q;
    end
  end

  // --------------------
  // FP bank
  // --------------------

  if (fpu_en != 0)
  begin : g_fp
    // All 32 words exist, FP word 0 is writable
    logic [data_width-1:0] mem_fp [RF_BANK_WORDS];

    // Clocks and selects of the FP bank sit above the integer range
    always_latch
    begin
      for (int k = 0; k < RF_BANK_WORDS; k++)
      begin
        if (wr.word_clk[RF_BANK_WORDS + k] &&
            (wr.sel_a_q[RF_BANK_WORDS + k] || wr.sel_b_q[RF_BANK_WORDS + k]))
          mem_fp[k] <= wr.sel_b_q[RF_BANK_WORDS + k] ? wr.wdata_b_q : wr.wdata_a_q;
      end
    end

    for (genvar p = 0; p < RF_RD_PORTS; p++)
    begin : g_rd_fp
      assign rdata_fp[p] = mem_fp[raddr[p].bank.idx];
    end
  end
  else
  begin : g_no_fp
    // No FP storage, mux input never chosen
    for (genvar p = 0; p < RF_RD_PORTS; p++)
    begin : g_rd_fp
      assign rdata_fp[p] = '0;
    end
  end

  // --------------------
  // Read muxes
  // --------------------

  assign fp_ena = (fpu_en != 0) & ~fregfile_disable_i;

  assign raddr[0] = raddr_a_i;
  assign raddr[1] = raddr_b_i;
  assign raddr[2] = raddr_c_i;

  for (genvar p = 0; p < RF_RD_PORTS; p++)
  begin : g_rd
    logic [data_width-1:0] int_word;

    // x0 reads zero
    assign int_word = (raddr[p].bank.idx == '0) ? '0 : mem_int[raddr[p].bank.idx];

    // Disabled FP bank folds onto the integer word with the same index
    assign rdata[p] = (fp_ena && (raddr[p].bank.bank == bank_fp)) ? rdata_fp[p]
                                                                   : int_word;
  end

  assign rdata_a_o = rdata[0];
  assign rdata_b_o = rdata[1];
  assign rdata_c_o = rdata[2];

endmodule : rf_latch_array

// ==== verilog/rf_top.sv ====
`timescale 1ns/1ns

// Latch-based register file, three read and two write ports
// Integer bank always, FP bank when fpu_en is set
module rf_top #(
  parameter int data_width = 32,
  parameter int fpu_en     = 1
) (
  input  logic                                clk_int,
  input  logic                                rst_n,

  input  logic                                test_en_i,
  input  logic                                fregfile_disable_i,

  // Read ports
  input  logic [rf_cfg_pkg::RF_ADDR_W-1:0]    raddr_a_i,
  output logic [data_width-1:0]               rdata_a_o,
  input  logic [rf_cfg_pkg::RF_ADDR_W-1:0]    raddr_b_i,
  output logic [data_width-1:0]               rdata_b_o,
  input  logic [rf_cfg_pkg::RF_ADDR_W-1:0]    raddr_c_i,
  output logic [data_width-1:0]               rdata_c_o,

  // Write port A
  input  logic [rf_cfg_pkg::RF_ADDR_W-1:0]    waddr_a_i,
  input  logic [data_width-1:0]               wdata_a_i,
  input  logic                                we_a_i,

  // Write port B, wins on a shared word
  input  logic [rf_cfg_pkg::RF_ADDR_W-1:0]    waddr_b_i,
  input  logic [data_width-1:0]               wdata_b_i,
  input  logic                                we_b_i
);

  // Sampled write bundle between controller and storage
  rf_wr_if #(
    .data_width (data_width)
  ) wr_if ();

  // --------------------
  // Write side
  // --------------------

  rf_write_ctrl #(
    .data_width (data_width),
    .fpu_en     (fpu_en)
  ) u_write_ctrl (
    .clk_int            (clk_int),
    .rst_n              (rst_n),
    .test_en_i          (test_en_i),
    .fregfile_disable_i (fregfile_disable_i),
    .waddr_a_i          (waddr_a_i),
    .wdata_a_i          (wdata_a_i),
    .we_a_i             (we_a_i),
    .waddr_b_i          (waddr_b_i),
    .wdata_b_i          (wdata_b_i),
    .we_b_i             (we_b_i),
    .wr                 (wr_if.ctrl)
  );

  // --------------------
  // Storage and reads
  // --------------------

  rf_latch_array #(
    .data_width (data_width),
    .fpu_en     (fpu_en)
  ) u_latch_array (
    .fregfile_disable_i (fregfile_disable_i),
    .raddr_a_i          (raddr_a_i),
    .raddr_b_i          (raddr_b_i),
    .raddr_c_i          (raddr_c_i),
    .wr                 (wr_if.array),
    .rdata_a_o          (rdata_a_o),
    .rdata_b_o          (rdata_b_o),
    .rdata_c_o          (rdata_c_o)
  );

endmodule : rf_top

// ==== test/rf_sva.sv ====
`timescale 1ns/1ns

// Concurrent checks on the write controller
// Bound into every rf_write_ctrl instance
module rf_wr_sva (
  input logic                                 clk_int,
  input logic                                 rst_n,
  input logic                                 test_en_i,
  input logic                                 we_a_i,
  input logic                                 we_b_i,
  input logic [rf_cfg_pkg::RF_MAX_WORDS-1:0]  sel_a,
  input logic [rf_cfg_pkg::RF_MAX_WORDS-1:0]  sel_b,
  input logic [rf_cfg_pkg::RF_MAX_WORDS-1:0]  sel_b_q,
  input logic [rf_cfg_pkg::RF_MAX_WORDS-1:0]  word_clk
);

  // --------------------
  // Decoders
  // --------------------

  // At most one word per port and cycle
  onehot_a: assert property (@(posedge clk_int) disable iff (!rst_n) $onehot0(sel_a))
    else $error("Port A word select has more than one bit set");

  onehot_b: assert property (@(posedge clk_int) disable iff (!rst_n) $onehot0(sel_b))
    else $error("Port B word select has more than one bit set");

  // x0 has no storage, so it is never selected
  x0_unselected: assert property (@(posedge clk_int) disable iff (!rst_n)
    !sel_a[0] && !sel_b[0] && !sel_b_q[0])
    else $error("Word 0 select is set");

  // --------------------
  // Sampled select and clocks
  // --------------------

  // A nonzero new select needs a port B write at the sample edge
  sel_b_q_stable: assert property (@(posedge clk_int) disable iff (!rst_n)
    $changed(sel_b_q) |-> ($past(we_b_i) || (sel_b_q == '0)))
    else $error("Registered port B select changed without a port B write");

  // High phase after an idle edge keeps every word clock low
  // Values sampled at the previous falling edge were the ones seen by that edge
  word_clk_idle: assert property (@(negedge clk_int) disable iff (!rst_n)
    $past(!we_a_i && !we_b_i && !test_en_i) |-> (word_clk == '0))
    else $error("Word clock pulsed with no write and test mode off");

endmodule : rf_wr_sva

bind rf_write_ctrl rf_wr_sva u_wr_sva (
  .clk_int   (clk_int),
  .rst_n     (rst_n),
  .test_en_i (test_en_i),
  .we_a_i    (we_a_i),
  .we_b_i    (we_b_i),
  .sel_a     (sel_a),
  .sel_b     (sel_b),
  .sel_b_q   (wr.sel_b_q),
  .word_clk  (wr.word_clk)
);

// ==== test/rf_tb.sv ====
`timescale 1ns/1ns

// Testbench of the latch register file
// LFSR traffic on both write ports and all read ports checked against a word model
module rf_tb;

  logic        clk_int;
  logic        rst_n;
  logic        test_en_i;
  logic        fregfile_disable_i;
  logic [5:0]  raddr_a_i;
  logic [5:0]  raddr_b_i;
  logic [5:0]  raddr_c_i;
  logic [31:0] rdata_a_o;
  logic [31:0] rdata_b_o;
  logic [31:0] rdata_c_o;
  logic [5:0]  waddr_a_i;
  logic [5:0]  waddr_b_i;
  logic [31:0] wdata_a_i;
  logic [31:0] wdata_b_i;
  logic        we_a_i;
  logic        we_b_i;

  // Reference model indexed by flat word number
  // Entry 0 stays unused
  logic [31:0] model [64];
  logic [31:0] lfsr;
  logic [5:0]  prev_wa;
  // Mode bits applied with the next driven cycle
  logic        dis_next;
  logic        ten_next;
  logic        test_done;
  int          err_count;
  int          check_count;

  rf_top #(
    .data_width (32),
    .fpu_en     (1)
  ) rf_top_inst (.*);

  initial
  begin
    clk_int = 1'b0;
    forever #4 clk_int = ~clk_int;
  end

  // --------------------
  // Helpers
  // --------------------

  // Galois LFSR with taps x^32 + x^22 + x^2 + x + 1
  // One step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      val = {val[30:0], lfsr[0]};
    end
    return val;
  endfunction

  // Disabled FP bank maps onto the integer word with the same index
  function automatic logic [5:0] fold_addr(input logic [5:0] addr);
    return fregfile_disable_i ? {1'b0, addr[4:0]} : addr;
  endfunction

  function automatic logic [31:0] expect_read(input logic [5:0] addr);
    logic [5:0] a;
    a = fold_addr(addr);
    return (a == 6'd0) ? 32'd0 : model[a];
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    check_count++;
    if (got !== exp)
    begin
      err_count++;
      $display("[ERROR] %0t ns %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // Commits the write that ends at this edge
  // Then drives the next cycle and checks its reads
  task automatic run_cycle(
    input logic wea, input logic [5:0] wa, input logic [31:0] da,
    input logic web, input logic [5:0] wb, input logic [31:0] db,
    input logic [5:0] ra, input logic [5:0] rb, input logic [5:0] rc
  );
    logic [5:0] a;
    logic [5:0] b;
    @(posedge clk_int);
    a = fold_addr(waddr_a_i);
    b = fold_addr(waddr_b_i);
    if (we_a_i && (a != 6'd0))
      model[a] = wdata_a_i;
    // B goes second and wins a shared word
    if (we_b_i && (b != 6'd0))
      model[b] = wdata_b_i;
    we_a_i             <= wea;
    waddr_a_i          <= wa;
    wdata_a_i          <= da;
    we_b_i             <= web;
    waddr_b_i          <= wb;
    wdata_b_i          <= db;
    raddr_a_i          <= ra;
    raddr_b_i          <= rb;
    raddr_c_i          <= rc;
    fregfile_disable_i <= dis_next;
    test_en_i          <= ten_next;
    // Mid cycle with latches closed and addresses settled
    @(negedge clk_int);
    check_value("rdata_a_o", rdata_a_o, expect_read(raddr_a_i));
    check_value("rdata_b_o", rdata_b_o, expect_read(raddr_b_i));
    check_value("rdata_c_o", rdata_c_o, expect_read(raddr_c_i));
  endtask

  // Port A reads the word in flight and sees its old value
  // Port B reads the word written one cycle earlier
  task automatic rand_cycle(input logic wen, input logic same);
    logic [5:0] wa;
    logic [5:0] wb;
    logic       wea;
    logic       web;
    wa  = 6'(rand_bits(6));
    wb  = same ? wa : 6'(rand_bits(6));
    wea = wen & (same | 1'(rand_bits(1)));
    web = wen & (same | 1'(rand_bits(1)));
    run_cycle(wea, wa, rand_bits(32), web, wb, rand_bits(32), wa, prev_wa, 6'(rand_bits(6)));
    prev_wa = wa;
  endtask

  // --------------------
  // Stimulus
  // --------------------

  initial
  begin
    lfsr               = 32'h62a4_9e85;
    err_count          = 0;
    check_count        = 0;
    test_done          = 1'b0;
    dis_next           = 1'b0;
    ten_next           = 1'b0;
    prev_wa            = 6'd0;
    rst_n              = 1'b0;
    test_en_i          = 1'b0;
    fregfile_disable_i = 1'b0;
    raddr_a_i          = 6'd0;
    raddr_b_i          = 6'd0;
    raddr_c_i          = 6'd0;
    waddr_a_i          = 6'd0;
    waddr_b_i          = 6'd0;
    wdata_a_i          = 32'd0;
    wdata_b_i          = 32'd0;
    we_a_i             = 1'b0;
    we_b_i             = 1'b0;
    repeat (16) @(posedge clk_int);
    rst_n <= 1'b1;

    // Latches power up unknown
    // Fill words 1..63 two at a time
    for (int w = 1; w < 64; w += 2)
      run_cycle(1'b1, 6'(w), rand_bits(32), 1'b1, 6'(w + 1), rand_bits(32),
                6'd0, 6'd0, 6'd0);

    // Independent banks
    repeat (400) rand_cycle(1'b1, 1'b0);
    // Same word on both ports
    repeat (40) rand_cycle(1'b1, 1'b1);

    // x0 drops writes from both ports
    run_cycle(1'b1, 6'd0, rand_bits(32), 1'b1, 6'd0, rand_bits(32), 6'd0, 6'd0, 6'd0);
    run_cycle(1'b0, 6'd0, 32'd0, 1'b0, 6'd0, 32'd0, 6'd0, 6'd0, 6'd0);

    // FP word 0 is real storage
    run_cycle(1'b1, 6'd32, rand_bits(32), 1'b0, 6'd0, 32'd0, 6'd32, 6'd0, 6'd32);
    run_cycle(1'b0, 6'd0, 32'd0, 1'b0, 6'd0, 32'd0, 6'd32, 6'd0, 6'd1);

    // Folded FP addresses and then back to two banks
    dis_next = 1'b1;
    repeat (200) rand_cycle(1'b1, 1'b0);
    dis_next = 1'b0;
    repeat (100) rand_cycle(1'b1, 1'b0);

    // Scan mode with no strobes and then a sweep of every word
    ten_next = 1'b1;
    repeat (8 + int'(rand_bits(5))) rand_cycle(1'b0, 1'b0);
    for (int w = 0; w < 64; w += 3)
      run_cycle(1'b0, 6'd0, 32'd0, 1'b0, 6'd0, 32'd0, 6'(w), 6'(w + 1), 6'(w + 2));
    ten_next = 1'b0;
    repeat (50) rand_cycle(1'b1, 1'b0);
    test_done = 1'b1;
  end

  // Bounded wait for the stimulus before the verdict
  initial
  begin
    for (int cyc = 0; (cyc < 5000) && !test_done; cyc++)
      @(posedge clk_int);
    if (!test_done)
    begin
      err_count++;
      $display("Timeout: stimulus did not finish within 5000 cycles");
    end
    $display("Checks: %0d, errors: %0d", check_count, err_count);
    if (err_count == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule : rf_tb

// ==== sources.f ====
verilog/rf_cfg_pkg.sv
verilog/rf_addr_pkg.sv
verilog/rf_clock_gate.sv
verilog/rf_wr_if.sv
verilog/rf_write_ctrl.sv
verilog/rf_latch_array.sv
verilog/rf_top.sv
test/rf_sva.sv
test/rf_tb.sv

// ==== Makefile ====
# Verilator build and run of the register file testbench

LOG = sim.log

all: run

compile:
	verilator --binary --timing --assert --top-module rf_tb -f sources.f -Mdir obj_dir -o Vrf_tb

run: compile
	-./obj_dir/Vrf_tb > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "STATUS: PASS" $(LOG) || (echo "Simulation ended without a status"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: all compile run clean
